// ==== pad_frame_top.f ====
common/pad_pkg.sv
common/sensor_pkg.sv
padring/pad_cell_bank.sv
logic/jtag_overlay_mux.sv
logic/sensor_alert_handshake.sv
logic/pad_frame_top.sv
testbench/tb_clk_gen.sv
testbench/pad_frame_chk.sv
testbench/pad_frame_tb.sv

// ==== Bender.yml ====
package:
  name: pad_frame_top

sources:
  # Packages first, then the RTL
  - common/pad_pkg.sv
  - common/sensor_pkg.sv
  - padring/pad_cell_bank.sv
  - logic/jtag_overlay_mux.sv
  - logic/sensor_alert_handshake.sv
  - logic/pad_frame_top.sv

  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/pad_frame_chk.sv
      - testbench/pad_frame_tb.sv

// ==== testbench/pad_frame_tb.sv ====
/* Pad frame testbench: LFSR-filled stimulus table, handshake reference,
   compare tasks, strap reset sequences, watchdog and final report */

`timescale 1ns/1ps
`default_nettype none

module pad_frame_tb;

  import pad_pkg::*;
  import sensor_pkg::*;

  localparam int NumRows    = 28;
  localparam int WatchdogNs = (NumRows + 40) * 20 * 4;
  localparam logic [NumPads-1:0] JtagPins = (NumPads'(1) << TckIdx) | (NumPads'(1) << TmsIdx) |
                                            (NumPads'(1) << TdiIdx) | (NumPads'(1) << TrstIdx);

  logic                 clk_main, rst_n, rst_req;
  logic [NumPads-1:0]   pad_in, pad_out, pad_oe, pad_attr;
  logic [NumPads-1:0]   core_out, core_oe, core_in;
  logic                 jtag_tck, jtag_tms, jtag_tdi, jtag_trst_n, jtag_tdo, jtag_active;
  logic [NumAlerts-1:0] sensor_event, alert_trig, alert_req, alert_ack;
  logic [31:0]          lfsr_state;
  int                   pad_errs, alert_errs, jtag_errs;

  // Stimulus table, one row per cycle
  logic [NumPads-1:0]   t_out  [NumRows];
  logic [NumPads-1:0]   t_oe   [NumRows];
  logic [NumPads-1:0]   t_attr [NumRows];
  logic [NumPads-1:0]   t_in   [NumRows];
  logic                 t_tdo  [NumRows];
  logic [NumAlerts-1:0] t_ev   [NumRows];
  logic [NumAlerts-1:0] t_trig [NumRows];
  logic [NumAlerts-1:0] t_ack  [NumRows];
  logic [NumAlerts-1:0] t_req  [NumRows];  // Expected req once the row is taken

  tb_clk_gen #(.PeriodNs(20), .ResetCycles(3)) u_clk_gen (
    .rst_req_i ( rst_req  ),
    .clk_o     ( clk_main ),
    .rst_n_o   ( rst_n    )
  );

  pad_frame_top pad_frame_top_inst (
    .clk_main_i (clk_main), .rst_n_i (rst_n), .pad_in_i (pad_in), .pad_out_o (pad_out),
    .pad_oe_o (pad_oe), .pad_attr_i (pad_attr), .core_out_i (core_out), .core_oe_i (core_oe),
    .core_in_o (core_in), .jtag_tck_o (jtag_tck), .jtag_tms_o (jtag_tms),
    .jtag_tdi_o (jtag_tdi), .jtag_trst_n_o (jtag_trst_n), .jtag_tdo_i (jtag_tdo),
    .jtag_active_o (jtag_active), .sensor_event_i (sensor_event), .alert_trig_i (alert_trig),
    .alert_req_o (alert_req), .alert_ack_i (alert_ack)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Random data and table setup
  ////////////////////////////////////////////////////////////////////////////

  // Taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic take_bit();
    lfsr_state = lfsr_next(lfsr_state);
    return lfsr_state[0];
  endfunction

  function automatic logic [NumPads-1:0] rand_pads();
    logic [NumPads-1:0] w;
    for (int k = 0; k < NumPads; k++) w[k] = take_bit();
    return w;
  endfunction

  task automatic hold_ack(input sensor_sel_e s, input int first, input int last);
    for (int r = first; r <= last; r++) t_ack[r][s] = 1'b1;
  endtask

  task automatic fill_table();
    for (int r = 0; r < NumRows; r++) begin
      t_out[r]  = rand_pads();
      t_oe[r]   = rand_pads();
      t_attr[r] = rand_pads();
      t_in[r]   = rand_pads();
      t_tdo[r]  = take_bit();
      t_ev[r]   = '0;
      t_trig[r] = '0;
      t_ack[r]  = '0;
    end
    t_ev[1][SENSOR_AS]   = 1'b1;  // Plain event
    hold_ack(SENSOR_AS, 3, 5);
    t_trig[2][SENSOR_OT] = 1'b1;  // Core test trigger
    hold_ack(SENSOR_OT, 4, 6);
    // Burst while ack is withheld
    t_ev[8][SENSOR_GD]  = 1'b1;
    t_ev[10][SENSOR_GD] = 1'b1;
    t_ev[12][SENSOR_GD] = 1'b1;
    t_ev[15][SENSOR_GD] = 1'b1;
    hold_ack(SENSOR_GD, 14, 16);
    hold_ack(SENSOR_GD, 20, 21);  // Answer to the merged request
  endtask

  // Four-phase reference model of each alert channel
  task automatic model_handshake();
    alert_hs_state_e st   [NumAlerts];
    logic            pend [NumAlerts];
    logic            hit;
    for (int s = 0; s < NumAlerts; s++) begin
      st[s]   = ALERT_IDLE;
      pend[s] = 1'b0;
    end
    for (int r = 0; r < NumRows; r++) begin
      for (int s = 0; s < NumAlerts; s++) begin
        hit = t_ev[r][s] | t_trig[r][s];
        if (st[s] == ALERT_IDLE) begin
          if (hit || pend[s]) begin
            st[s]   = ALERT_REQ;
            pend[s] = 1'b0;
          end
        end else begin
          pend[s] = pend[s] | hit;  // Busy channel merges events
          if (st[s] == ALERT_REQ && t_ack[r][s]) st[s] = ALERT_RELEASE;
          else if (st[s] == ALERT_RELEASE && !t_ack[r][s]) st[s] = ALERT_IDLE;
        end
        t_req[r][s] = (st[s] == ALERT_REQ);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Expected values and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic expect_pads(input int r, input bit jtag,
                             output logic [NumPads-1:0] e_out, output logic [NumPads-1:0] e_oe);
    logic [NumPads-1:0] out_v;
    logic [NumPads-1:0] oe_v;
    logic               val;
    out_v = t_out[r];
    oe_v  = t_oe[r];
    if (jtag) begin
      out_v[TdoIdx] = t_tdo[r];
      oe_v[TdoIdx]  = 1'b1;
    end
    for (int k = 0; k < NumPads; k++) begin
      val = out_v[k] ^ t_attr[r][k];
      case (DefaultPadVariants[k])
        PAD_INPUT_ONLY: begin
          e_out[k] = 1'b0;
          e_oe[k]  = 1'b0;
        end
        PAD_OPEN_DRAIN: begin
          e_out[k] = 1'b0;
          e_oe[k]  = oe_v[k] & ~val;  // Drives only a low level
        end
        default: begin
          e_out[k] = val;
          e_oe[k]  = oe_v[k];
        end
      endcase
    end
  endtask

  task automatic check_pads(input string name, input logic [NumPads-1:0] got, exp);
    if (got !== exp) begin
      pad_errs++;
      $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_alerts(input string name, input logic [NumAlerts-1:0] got, exp);
    if (got !== exp) begin
      alert_errs++;
      $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_jtag(input string name, input logic got, exp);
    if (got !== exp) begin
      jtag_errs++;
      $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_reset_state();
    check_pads("pad_out_o", pad_out, '0);
    check_pads("pad_oe_o", pad_oe, '0);
    check_alerts("alert_req_o", alert_req, '0);
    check_jtag("jtag_active_o", jtag_active, 1'b0);
    check_jtag("jtag_trst_n_o", jtag_trst_n, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequences
  ////////////////////////////////////////////////////////////////////////////

  task automatic await_reset_and_window(input bit strap);
    @(posedge rst_n);
    @(negedge clk_main);
    check_reset_state();
    repeat (StrapSampleCycles + 2) @(posedge clk_main);
    @(negedge clk_main);
    check_jtag("jtag_active_o", jtag_active, strap);
  endtask

  task automatic reset_with_strap(input bit strap);
    @(posedge clk_main);
    rst_req      <= 1'b1;
    pad_in       <= strap ? (NumPads'(1) << JtagEnIdx) : '0;  // Strap held through window
    pad_attr     <= '0;
    core_out     <= '1;  // Pads driving going into reset
    core_oe      <= '1;
    jtag_tdo     <= 1'b0;
    sensor_event <= '1;  // All channels busy going into reset
    alert_trig   <= '0;
    alert_ack    <= '0;
    @(posedge clk_main);
    rst_req      <= 1'b0;
    sensor_event <= '0;
    await_reset_and_window(strap);
  endtask

  task automatic run_table(input bit jtag);
    logic [NumPads-1:0] e_out;
    logic [NumPads-1:0] e_oe;
    logic [NumPads-1:0] e_in;
    for (int r = 0; r < NumRows; r++) begin
      @(posedge clk_main);
      core_out     <= t_out[r];
      core_oe      <= t_oe[r];
      pad_attr     <= t_attr[r];
      pad_in       <= t_in[r];
      jtag_tdo     <= t_tdo[r];
      sensor_event <= t_ev[r];
      alert_trig   <= t_trig[r];
      alert_ack    <= t_ack[r];
      @(negedge clk_main);
      check_jtag("jtag_active_o", jtag_active, jtag);
      if (r >= 1) begin
        expect_pads(r - 1, jtag, e_out, e_oe);
        check_pads("pad_out_o", pad_out, e_out);
        check_pads("pad_oe_o", pad_oe, e_oe);
        check_alerts("alert_req_o", alert_req, t_req[r - 1]);
      end
      if (r >= 2) begin
        e_in = t_in[r - 2] ^ t_attr[r];
        check_jtag("jtag_tck_o", jtag_tck, jtag & e_in[TckIdx]);
        check_jtag("jtag_tms_o", jtag_tms, jtag & e_in[TmsIdx]);
        check_jtag("jtag_tdi_o", jtag_tdi, jtag & e_in[TdiIdx]);
        check_jtag("jtag_trst_n_o", jtag_trst_n, jtag & e_in[TrstIdx]);
        if (jtag) e_in = (e_in & ~JtagPins) | (JtagTieOff & JtagPins);
        check_pads("core_in_o", core_in, e_in);
      end
    end
  endtask

  initial begin
    #(WatchdogNs);
    $display("Timeout: run did not finish within %0d ns", WatchdogNs);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    rst_req      = 1'b0;
    pad_in       = NumPads'(1) << JtagEnIdx;  // Strap high from time zero
    pad_attr     = '0;
    core_out     = '0;
    core_oe      = '0;
    jtag_tdo     = 1'b0;
    sensor_event = '0;
    alert_trig   = '0;
    alert_ack    = '0;
    pad_errs     = 0;
    alert_errs   = 0;
    jtag_errs    = 0;
    lfsr_state   = 32'h4295_2ea9;
    fill_table();
    model_handshake();
    await_reset_and_window(1'b1);
    run_table(1'b1);
    reset_with_strap(1'b0);  // Strap low, all pads pass through
    run_table(1'b0);
    $display("Errors: pad %0d, alert %0d, jtag %0d", pad_errs, alert_errs, jtag_errs);
    if (pad_errs + alert_errs + jtag_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule : pad_frame_tb

`default_nettype wire

// ==== testbench/pad_frame_chk.sv ====
/* Handshake and reset assertions for the sensor alert unit */

`timescale 1ns/1ps
`default_nettype none

module pad_frame_chk #(
  parameter int NumAlerts = sensor_pkg::NumAlerts
) (
  input logic                 clk_main_i,
  input logic                 rst_n_i,
  input logic [NumAlerts-1:0] alert_req_i,
  input logic [NumAlerts-1:0] alert_ack_i
);

  // req never drops before the core answers
  for (genvar i = 0; i < NumAlerts; i++) begin : g_chan
    req_held_until_ack : assert property (@(posedge clk_main_i) disable iff (!rst_n_i)
      (alert_req_i[i] && !alert_ack_i[i]) |=> alert_req_i[i])
      else $error("alert_req_o[%0d] fell before ack", i);

    no_rise_under_ack : assert property (@(posedge clk_main_i) disable iff (!rst_n_i)
      (!alert_req_i[i] && alert_ack_i[i]) |=> !alert_req_i[i])
      else $error("alert_req_o[%0d] rose while ack was still high", i);
  end

  req_clear_after_reset : assert property (@(posedge clk_main_i)
    !rst_n_i |=> (alert_req_i == '0))
    else $error("alert_req_o not clear after reset");

endmodule : pad_frame_chk

bind sensor_alert_handshake pad_frame_chk #(.NumAlerts(NumAlerts)) u_pad_frame_chk (
  .clk_main_i  ( clk_main_i  ),
  .rst_n_i     ( rst_n_i     ),
  .alert_req_i ( alert_req_o ),
  .alert_ack_i ( alert_ack_i )
);

`default_nettype wire

// ==== testbench/tb_clk_gen.sv ====
/* Testbench clock and reset source with on-demand reset pulses */

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PeriodNs    = 20,
  parameter int ResetCycles = 3
) (
  input  logic rst_req_i,  // Pulse for one cycle to reset again
  output logic clk_o,
  output logic rst_n_o
);

  initial clk_o = 1'b0;
  always #(PeriodNs / 2) clk_o = ~clk_o;

  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_n_o <= 1'b1;
    forever begin
      @(posedge clk_o);
      if (rst_req_i) begin
        rst_n_o <= 1'b0;
        repeat (ResetCycles) @(posedge clk_o);
        rst_n_o <= 1'b1;
      end
    end
  end

endmodule : tb_clk_gen

`default_nettype wire

// ==== logic/pad_frame_top.sv ====
/* Pad frame top: pad cell bank, JTAG overlay mux and sensor alert
   handshake wired between pads and core */

`timescale 1ns/1ps
`default_nettype none

module pad_frame_top (
  input  logic                             clk_main_i,
  input  logic                             rst_n_i,
  // Pads
  input  logic [pad_pkg::NumPads-1:0]      pad_in_i,
  output logic [pad_pkg::NumPads-1:0]      pad_out_o,
  output logic [pad_pkg::NumPads-1:0]      pad_oe_o,
  input  logic [pad_pkg::NumPads-1:0]      pad_attr_i,
  // Core I/O
  input  logic [pad_pkg::NumPads-1:0]      core_out_i,
  input  logic [pad_pkg::NumPads-1:0]      core_oe_i,
  output logic [pad_pkg::NumPads-1:0]      core_in_o,
  // JTAG
  output logic                             jtag_tck_o,
  output logic                             jtag_tms_o,
  output logic                             jtag_tdi_o,
  output logic                             jtag_trst_n_o,
  input  logic                             jtag_tdo_i,
  output logic                             jtag_active_o,
  // Sensor alerts
  input  logic [sensor_pkg::NumAlerts-1:0] sensor_event_i,
  input  logic [sensor_pkg::NumAlerts-1:0] alert_trig_i,
  output logic [sensor_pkg::NumAlerts-1:0] alert_req_o,
  input  logic [sensor_pkg::NumAlerts-1:0] alert_ack_i
);

  import pad_pkg::*;
  import sensor_pkg::*;

  // Padring-side vectors between cell bank and overlay mux
  logic [NumPads-1:0] pc_out;
  logic [NumPads-1:0] pc_oe;
  logic [NumPads-1:0] pc_in;

  ////////////////////////////////////////////////////////////////////////////
  // Pad ring and JTAG overlay
  ////////////////////////////////////////////////////////////////////////////

  pad_cell_bank #(
    .NumPads     ( NumPads            ),
    .PadVariants ( DefaultPadVariants )
  ) u_pad_cell_bank (
    .clk_main_i ( clk_main_i ),
    .rst_n_i    ( rst_n_i    ),
    .pad_in_i   ( pad_in_i   ),
    .pad_out_o  ( pad_out_o  ),
    .pad_oe_o   ( pad_oe_o   ),
    .pad_attr_i ( pad_attr_i ),
    .core_out_i ( pc_out     ),
    .core_oe_i  ( pc_oe      ),
    .core_in_o  ( pc_in      )
  );

  jtag_overlay_mux #(
    .NumPads           ( NumPads           ),
    .JtagEnIdx         ( JtagEnIdx         ),
    .TckIdx            ( TckIdx            ),
    .TmsIdx            ( TmsIdx            ),
    .TdiIdx            ( TdiIdx            ),
    .TrstIdx           ( TrstIdx           ),
    .TdoIdx            ( TdoIdx            ),
    .JtagTieOff        ( JtagTieOff        ),
    .StrapSampleCycles ( StrapSampleCycles )
  ) u_jtag_overlay_mux (
    .clk_main_i    ( clk_main_i    ),
    .rst_n_i       ( rst_n_i       ),
    .out_core_i    ( core_out_i    ),
    .oe_core_i     ( core_oe_i     ),
    .in_core_o     ( core_in_o     ),
    .out_padring_o ( pc_out        ),
    .oe_padring_o  ( pc_oe         ),
    .in_padring_i  ( pc_in         ),
    .jtag_tck_o    ( jtag_tck_o    ),
    .jtag_tms_o    ( jtag_tms_o    ),
    .jtag_tdi_o    ( jtag_tdi_o    ),
    .jtag_trst_n_o ( jtag_trst_n_o ),
    .jtag_tdo_i    ( jtag_tdo_i    ),
    .jtag_active_o ( jtag_active_o )
  );

  // Analog sensor alerts toward the core
  sensor_alert_handshake #(
    .NumAlerts ( NumAlerts )
  ) u_sensor_alert_handshake (
    .clk_main_i     ( clk_main_i     ),
    .rst_n_i        ( rst_n_i        ),
    .sensor_event_i ( sensor_event_i ),
    .alert_trig_i   ( alert_trig_i   ),
    .alert_ack_i    ( alert_ack_i    ),
    .alert_req_o    ( alert_req_o    )
  );

endmodule : pad_frame_top

`default_nettype wire

// ==== logic/sensor_alert_handshake.sv ====
/* Sensor alert handshake: one four-phase req/ack FSM per sensor
   with a pending bit for events that arrive while busy */

`timescale 1ns/1ps
`default_nettype none

module sensor_alert_handshake #(
  parameter int NumAlerts = sensor_pkg::NumAlerts
) (
  input  logic                 clk_main_i,
  input  logic                 rst_n_i,
  input  logic [NumAlerts-1:0] sensor_event_i,
  input  logic [NumAlerts-1:0] alert_trig_i,   // Core test trigger
  input  logic [NumAlerts-1:0] alert_ack_i,
  output logic [NumAlerts-1:0] alert_req_o
);

  import sensor_pkg::*;

  logic [NumAlerts-1:0] alert_hit;  // Event or trigger this cycle

  assign alert_hit = sensor_event_i | alert_trig_i;

  ////////////////////////////////////////////////////////////////////////////
  // Per-sensor channels
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NumAlerts; i++) begin : g_chan
    alert_hs_state_e state_d;
    alert_hs_state_e state_q;
    logic            pend_d;
    logic            pend_q;

    always_comb begin
      state_d = state_q;
      pend_d  = pend_q;
      case (state_q)
        ALERT_IDLE: begin
          if (alert_hit[i] || pend_q) begin
            state_d = ALERT_REQ;
            pend_d  = 1'b0;  // Pending event consumed here
          end
        end
        ALERT_REQ: begin
          pend_d = pend_q | alert_hit[i];
          if (alert_ack_i[i]) begin
            state_d = ALERT_RELEASE;
          end
        end
        ALERT_RELEASE: begin
          pend_d = pend_q | alert_hit[i];
          if (!alert_ack_i[i]) begin
            state_d = ALERT_IDLE;  // Handshake complete
          end
        end
        default: begin
          state_d = ALERT_IDLE;
        end
      endcase
    end

    always_ff @(posedge clk_main_i) begin
      if (!rst_n_i) begin
        state_q <= ALERT_IDLE;
        pend_q  <= 1'b0;
      end else begin
        state_q <= state_d;
        pend_q  <= pend_d;
      end
    end

    assign alert_req_o[i] = (state_q == ALERT_REQ);
  end

endmodule : sensor_alert_handshake

`default_nettype wire

// ==== logic/jtag_overlay_mux.sv ====
/* JTAG overlay mux: strap sampling window, JTAG enable lock and
   pin stealing with core tie-offs */

`timescale 1ns/1ps
`default_nettype none

module jtag_overlay_mux #(
  parameter int                 NumPads           = pad_pkg::NumPads,
  parameter int                 JtagEnIdx         = pad_pkg::JtagEnIdx,
  parameter int                 TckIdx            = pad_pkg::TckIdx,
  parameter int                 TmsIdx            = pad_pkg::TmsIdx,
  parameter int                 TdiIdx            = pad_pkg::TdiIdx,
  parameter int                 TrstIdx           = pad_pkg::TrstIdx,
  parameter int                 TdoIdx            = pad_pkg::TdoIdx,
  parameter logic [NumPads-1:0] JtagTieOff        = pad_pkg::JtagTieOff,
  parameter int                 StrapSampleCycles = pad_pkg::StrapSampleCycles
) (
  input  logic               clk_main_i,
  input  logic               rst_n_i,
  // Core side
  input  logic [NumPads-1:0] out_core_i,
  input  logic [NumPads-1:0] oe_core_i,
  output logic [NumPads-1:0] in_core_o,
  // Padring side
  output logic [NumPads-1:0] out_padring_o,
  output logic [NumPads-1:0] oe_padring_o,
  input  logic [NumPads-1:0] in_padring_i,  // Already synchronized
  // JTAG toward the core TAP
  output logic               jtag_tck_o,
  output logic               jtag_tms_o,
  output logic               jtag_tdi_o,
  output logic               jtag_trst_n_o,
  input  logic               jtag_tdo_i,
  output logic               jtag_active_o
);

  localparam int CntW = $clog2(StrapSampleCycles + 1);

  // Input pads taken over while JTAG is active
  localparam logic [NumPads-1:0] StolenMask = (NumPads'(1) << TckIdx) |
                                              (NumPads'(1) << TmsIdx) |
                                              (NumPads'(1) << TdiIdx) |
                                              (NumPads'(1) << TrstIdx);

  logic [CntW-1:0] win_cnt_q;
  logic            win_open;       // Inside sampling window
  logic            win_last;
  logic            strap_acc_q;
  logic            jtag_active_q;  // Locked until next reset

  ////////////////////////////////////////////////////////////////////////////
  // Strap sampling
  ////////////////////////////////////////////////////////////////////////////

  assign win_open = (win_cnt_q < CntW'(StrapSampleCycles));
  assign win_last = (win_cnt_q == CntW'(StrapSampleCycles - 1));

  always_ff @(posedge clk_main_i) begin
    if (!rst_n_i) begin
      win_cnt_q     <= '0;
      strap_acc_q   <= 1'b0;
      jtag_active_q <= 1'b0;
    end else if (win_open) begin
      win_cnt_q   <= win_cnt_q + CntW'(1);
      strap_acc_q <= strap_acc_q | in_padring_i[JtagEnIdx];
      if (win_last) begin
        jtag_active_q <= strap_acc_q | in_padring_i[JtagEnIdx];
      end
    end
  end

  // Pin stealing
  always_comb begin
    in_core_o     = in_padring_i;
    out_padring_o = out_core_i;
    oe_padring_o  = oe_core_i;
    if (jtag_active_q) begin
      in_core_o             = (in_padring_i & ~StolenMask) | (JtagTieOff & StolenMask);
      out_padring_o[TdoIdx] = jtag_tdo_i;
      oe_padring_o[TdoIdx]  = 1'b1;
    end
  end

  assign jtag_tck_o    = jtag_active_q & in_padring_i[TckIdx];
  assign jtag_tms_o    = jtag_active_q & in_padring_i[TmsIdx];
  assign jtag_tdi_o    = jtag_active_q & in_padring_i[TdiIdx];
  assign jtag_trst_n_o = jtag_active_q & in_padring_i[TrstIdx];  // TAP held in reset
  assign jtag_active_o = jtag_active_q;

endmodule : jtag_overlay_mux

`default_nettype wire

// ==== padring/pad_cell_bank.sv ====
/* Pad cell bank: per-pad variant and invert handling, output
   registers and two-flop input synchronizer */

`timescale 1ns/1ps
`default_nettype none

module pad_cell_bank #(
  parameter int                                  NumPads     = pad_pkg::NumPads,
  parameter pad_pkg::pad_variant_e [NumPads-1:0] PadVariants = pad_pkg::DefaultPadVariants
) (
  input  logic               clk_main_i,
  input  logic               rst_n_i,
  // Pad side
  input  logic [NumPads-1:0] pad_in_i,
  output logic [NumPads-1:0] pad_out_o,
  output logic [NumPads-1:0] pad_oe_o,
  input  logic [NumPads-1:0] pad_attr_i,  // Invert per pad
  // Core side
  input  logic [NumPads-1:0] core_out_i,
  input  logic [NumPads-1:0] core_oe_i,
  output logic [NumPads-1:0] core_in_o
);

  import pad_pkg::*;

  logic [NumPads-1:0] out_val;  // Core value after invert
  logic [NumPads-1:0] out_d;
  logic [NumPads-1:0] oe_d;
  logic [NumPads-1:0] out_q;
  logic [NumPads-1:0] oe_q;
  logic [NumPads-1:0] sync1_q;
  logic [NumPads-1:0] sync2_q;

  ////////////////////////////////////////////////////////////////////////////
  // Output path
  ////////////////////////////////////////////////////////////////////////////

  assign out_val = core_out_i ^ pad_attr_i;

  always_comb begin
    for (int k = 0; k < NumPads; k++) begin
      case (PadVariants[k])
        PAD_INPUT_ONLY: begin
          out_d[k] = 1'b0;  // Never drives
          oe_d[k]  = 1'b0;
        end
        PAD_OPEN_DRAIN: begin
          // Pulls low only
          out_d[k] = 1'b0;
          oe_d[k]  = core_oe_i[k] & ~out_val[k];
        end
        default: begin
          out_d[k] = out_val[k];
          oe_d[k]  = core_oe_i[k];
        end
      endcase
    end
  end

  always_ff @(posedge clk_main_i) begin
    if (!rst_n_i) begin
      out_q <= '0;
      oe_q  <= '0;
    end else begin
      out_q <= out_d;
      oe_q  <= oe_d;
    end
  end

  assign pad_out_o = out_q;
  assign pad_oe_o  = oe_q;

  // Input path: pads are asynchronous to the core clock
  always_ff @(posedge clk_main_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= pad_in_i;
      sync2_q <= sync1_q;
    end
  end

  assign core_in_o = sync2_q ^ pad_attr_i;

endmodule : pad_cell_bank

`default_nettype wire

// ==== common/sensor_pkg.sv ====
/* Sensor alert definitions: sensor selectors, alert count and
   handshake state encoding */

`default_nettype none

package sensor_pkg;

  // One alert channel per analog sensor
  typedef enum logic [2:0] {
    SENSOR_AS    = 3'd0,
    SENSOR_CG    = 3'd1,
    SENSOR_GD    = 3'd2,
    SENSOR_TS_HI = 3'd3,
    SENSOR_TS_LO = 3'd4,
    SENSOR_LS    = 3'd5,
    SENSOR_OT    = 3'd6   // Last selector
  } sensor_sel_e;

  parameter int NumAlerts = int'(SENSOR_OT) + 1;

  ////////////////////////////////////////////////////////////////////////////
  // Four-phase req/ack channel
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    ALERT_IDLE    = 2'd0,  // Free for a new request
    ALERT_REQ     = 2'd1,  // req high until ack
    ALERT_RELEASE = 2'd2   // req low until ack drops
  } alert_hs_state_e;

endpackage

`default_nettype wire

// ==== common/pad_pkg.sv ====
/* Pad ring constants: pad counts, pad variant encoding, default variant
   table, JTAG pin map, tie-off word and strap sampling window */

`default_nettype none

package pad_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Pad counts
  ////////////////////////////////////////////////////////////////////////////

  parameter int NumMioPads = 8;  // Muxed pads
  parameter int NumDioPads = 6;  // Dedicated pads
  parameter int NumPads    = NumMioPads + NumDioPads;

  // Pad cell flavours
  typedef enum logic [1:0] {
    PAD_BIDIR      = 2'd0,
    PAD_INPUT_ONLY = 2'd1,
    PAD_OPEN_DRAIN = 2'd3
  } pad_variant_e;

  parameter pad_variant_e [NumPads-1:0] DefaultPadVariants = '{
    13:      PAD_INPUT_ONLY,  // JTAG TCK pad
    12:      PAD_INPUT_ONLY,  // JTAG TMS pad
    7:       PAD_OPEN_DRAIN,
    6:       PAD_OPEN_DRAIN,
    default: PAD_BIDIR
  };

  ////////////////////////////////////////////////////////////////////////////
  // JTAG overlay
  ////////////////////////////////////////////////////////////////////////////

  parameter int JtagEnIdx = 5;   // Strap pad
  parameter int TckIdx    = 13;
  parameter int TmsIdx    = 12;
  parameter int TdiIdx    = 8;
  parameter int TrstIdx   = 4;
  parameter int TdoIdx    = 9;   // Only output pad taken over

  // TMS pad doubles as an active-low chip select
  parameter logic [NumPads-1:0] JtagTieOff = NumPads'(1) << TmsIdx;

  // Strap window length in cycles
  parameter int StrapSampleCycles = 3;

endpackage

`default_nettype wire
